// File: Makefile
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP ?= dcache_tb
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= sim failed
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
design/dcache_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/miss_control.sv
design/mem_line_port.sv
design/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

// File: design/cache_data_store.sv
// line data of both ways, byte-enabled word writes, refill writes, word and line reads
`timescale 1ns/1ns
`default_nettype none

module cache_data_store import dcache_pkg::*; (
	input wire clk,
	input wire cache_req_t req,
	input wire lookup_t lookup,
	input wire write_hit,
	input wire fill_done,
	input wire [line_w-1:0] fill_data,
	output logic [word_w-1:0] read_data,
	output logic [line_w-1:0] victim_line
);

	logic [words_per_line-1:0][word_w-1:0] lines_q [num_ways][num_sets];

	logic [index_w-1:0] idx;
	logic [$clog2(words_per_line)-1:0] word_sel;

	assign idx = req.addr.f.index;
	assign word_sel = req.addr.f.offset[offset_w-1 -: $clog2(words_per_line)];

	// refill lands in the victim way, hits write the hit way
	always_ff @(posedge clk) begin
		if (fill_done) begin
			lines_q[lookup.victim_way][idx] <= fill_data;
		end else if (write_hit) begin
			for (int b = 0; b < word_w/8; b++) begin
				if (req.byte_en[b])
					lines_q[lookup.hit_way][idx][word_sel][8*b +: 8] <= req.wdata[8*b +: 8];
			end
		end
	end

	assign read_data = lines_q[lookup.hit_way][idx][word_sel];
	assign victim_line = lines_q[lookup.victim_way][idx]; // taken by the port on issue_wb

endmodule

`default_nettype wire

// File: design/cache_tag_store.sv
// tag, valid, dirty and lru arrays with hit detection, victim choice and snoop invalidation
`timescale 1ns/1ns
`default_nettype none

module cache_tag_store import dcache_pkg::*; (
	input wire clk,
	input wire reset,
	input wire req_valid,
	input wire cache_req_t req,
	input wire inval_valid,
	input wire cache_addr_u inval_addr,
	input wire install,
	input wire clean_victim,
	input wire touch_hit,
	output lookup_t lookup
);

	logic [tag_w-1:0] tags_q [num_ways][num_sets];
	logic [num_sets-1:0] valid_q [num_ways];
	logic [num_sets-1:0] dirty_q [num_ways];
	logic [num_sets-1:0] lru_q; // way to evict next

	logic [index_w-1:0] req_idx;
	logic [index_w-1:0] inval_idx;
	logic [num_ways-1:0] way_hit;
	logic [num_ways-1:0] inval_hit;
	logic victim;

	assign req_idx = req.addr.f.index;
	assign inval_idx = inval_addr.f.index;

	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			way_hit[w] = req_valid && valid_q[w][req_idx] &&
				tags_q[w][req_idx] == req.addr.f.tag;
			inval_hit[w] = valid_q[w][inval_idx] &&
				tags_q[w][inval_idx] == inval_addr.f.tag;
		end
	end

	// an empty way is filled before anything is evicted
	always_comb begin
		if (!valid_q[0][req_idx])
			victim = 1'b0;
		else if (!valid_q[1][req_idx])
			victim = 1'b1;
		else
			victim = lru_q[req_idx];
		lookup.hit = |way_hit;
		lookup.hit_way = way_hit[1];
		lookup.victim_way = victim;
		lookup.victim_valid = valid_q[victim][req_idx];
		lookup.victim_dirty = valid_q[victim][req_idx] && dirty_q[victim][req_idx];
		lookup.victim_tag = tags_q[victim][req_idx];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < num_ways; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			lru_q <= '0;
		end else begin
			if (inval_valid) begin
				for (int w = 0; w < num_ways; w++) begin
					if (inval_hit[w]) begin
						valid_q[w][inval_idx] <= 1'b0;
						dirty_q[w][inval_idx] <= 1'b0; // snooped copy is stale
					end
				end
			end
			if (touch_hit) begin
				lru_q[req_idx] <= ~lookup.hit_way;
				if (req.op == op_write)
					dirty_q[lookup.hit_way][req_idx] <= 1'b1;
			end
			if (clean_victim)
				dirty_q[lookup.victim_way][req_idx] <= 1'b0;
			if (install) begin
				valid_q[lookup.victim_way][req_idx] <= 1'b1;
				dirty_q[lookup.victim_way][req_idx] <= 1'b0;
				lru_q[req_idx] <= ~lookup.victim_way; // filled way is newest
			end
		end
	end

	always_ff @(posedge clk) begin
		if (install)
			tags_q[lookup.victim_way][req_idx] <= req.addr.f.tag;
	end

	// installs only go to a way that missed, so one copy per set
	a_one_way_hit: assert property (@(posedge clk) disable iff (reset)
		!(way_hit[0] && way_hit[1]))
		else $error("Error %0t way_hit expected one-hot got %b", $time, way_hit);

endmodule

`default_nettype wire

// File: design/dcache_pkg.sv
// address layout, request, lookup and writeback types, status codes
`default_nettype none

package dcache_pkg;

	localparam int addr_w = 64;
	localparam int offset_w = 6;
	localparam int index_w = 9;
	localparam int tag_w = 49;
	localparam int word_w = 64;
	localparam int words_per_line = 8;
	localparam int line_w = 512;
	localparam int num_sets = 512;
	localparam int num_ways = 2;

	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [index_w-1:0] index;
		logic [offset_w-1:0] offset;
	} addr_fields_t;

	// same address word, flat or split
	typedef union packed {
		logic [addr_w-1:0] raw;
		addr_fields_t f;
	} cache_addr_u;

	typedef enum logic [1:0] {
		op_none = 2'd0,
		op_read = 2'd1,
		op_write = 2'd2
	} cache_op_e;

	typedef struct packed {
		cache_op_e op;
		cache_addr_u addr;
		logic [word_w-1:0] wdata;
		logic [word_w/8-1:0] byte_en;
	} cache_req_t;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_wait = 2'd1, // transfer in flight
		st_hit = 2'd2,
		st_miss = 2'd3
	} cache_status_e;

	typedef struct packed {
		logic hit;
		logic hit_way;
		logic victim_way;
		logic victim_valid;
		logic victim_dirty;
		logic [tag_w-1:0] victim_tag;
	} lookup_t;

	typedef struct packed {
		logic [addr_w-1:0] addr; // line aligned
		logic [line_w-1:0] line;
	} wb_req_t;

endpackage

`default_nettype wire

// File: design/dcache_top.sv
// two-way write-back data cache, store and control instances
`timescale 1ns/1ns
`default_nettype none

module dcache_top import dcache_pkg::*; (
	input wire clk,
	input wire reset,
	input wire req_valid,
	input wire cache_req_t req,
	input wire inval_valid,
	input wire cache_addr_u inval_addr,
	input wire wb_done,
	input wire fill_done,
	input wire [line_w-1:0] fill_data,
	output cache_status_e status,
	output logic [word_w-1:0] read_data,
	output logic wb_start,
	output wb_req_t wb,
	output logic fill_start,
	output logic [addr_w-1:0] fill_addr
);

	lookup_t lookup;
	logic install;
	logic clean_victim;
	logic touch_hit;
	logic write_hit;
	logic issue_wb;
	logic issue_fill;
	logic [line_w-1:0] victim_line;

	cache_tag_store tag_store_i (
		.clk(clk), .reset(reset), .req_valid(req_valid), .req(req),
		.inval_valid(inval_valid), .inval_addr(inval_addr), .install(install),
		.clean_victim(clean_victim), .touch_hit(touch_hit), .lookup(lookup)
	);

	cache_data_store data_store_i (
		.clk(clk), .req(req), .lookup(lookup), .write_hit(write_hit),
		.fill_done(fill_done), .fill_data(fill_data), .read_data(read_data),
		.victim_line(victim_line)
	);

	miss_control miss_control_i (
		.clk(clk), .reset(reset), .req_valid(req_valid), .req(req),
		.inval_valid(inval_valid), .lookup(lookup), .wb_done(wb_done),
		.fill_done(fill_done), .status(status), .install(install),
		.clean_victim(clean_victim), .touch_hit(touch_hit), .write_hit(write_hit),
		.issue_wb(issue_wb), .issue_fill(issue_fill)
	);

	mem_line_port mem_port_i (
		.clk(clk), .reset(reset), .issue_wb(issue_wb), .issue_fill(issue_fill),
		.req(req), .lookup(lookup), .victim_line(victim_line), .wb_done(wb_done),
		.fill_done(fill_done), .wb_start(wb_start), .wb(wb), .fill_start(fill_start),
		.fill_addr(fill_addr)
	);

endmodule

`default_nettype wire

// File: design/mem_line_port.sv
// registered writeback and refill requests, start pulses, outstanding transfer flag
`timescale 1ns/1ns
`default_nettype none

module mem_line_port import dcache_pkg::*; (
	input wire clk,
	input wire reset,
	input wire issue_wb,
	input wire issue_fill,
	input wire cache_req_t req,
	input wire lookup_t lookup,
	input wire [line_w-1:0] victim_line,
	input wire wb_done,
	input wire fill_done,
	output logic wb_start,
	output wb_req_t wb,
	output logic fill_start,
	output logic [addr_w-1:0] fill_addr
);

	cache_addr_u victim_addr;
	cache_addr_u fill_line;
	logic busy_q;

	always_comb begin
		victim_addr.f.tag = lookup.victim_tag;
		victim_addr.f.index = req.addr.f.index;
		victim_addr.f.offset = '0;
		fill_line.raw = req.addr.raw;
		fill_line.f.offset = '0; // line aligned
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_start <= 1'b0;
			fill_start <= 1'b0;
			busy_q <= 1'b0;
		end else begin
			wb_start <= issue_wb;
			fill_start <= issue_fill;
			if (issue_wb || issue_fill)
				busy_q <= 1'b1;
			else if (wb_done || fill_done)
				busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_wb) begin
			wb.addr <= victim_addr.raw;
			wb.line <= victim_line;
		end
		if (issue_fill)
			fill_addr <= fill_line.raw;
	end

	a_single_transfer: assert property (@(posedge clk) disable iff (reset)
		(issue_wb || issue_fill) |-> !busy_q)
		else $error("Error %0t busy_q expected 0 got 1 at issue", $time);

	a_done_expected: assert property (@(posedge clk) disable iff (reset)
		(wb_done || fill_done) |-> busy_q)
		else $error("Error %0t busy_q expected 1 got 0 at done", $time);

endmodule

`default_nettype wire

// File: design/miss_control.sv
// miss sequencing FSM through writeback and refill, requester status
`timescale 1ns/1ns
`default_nettype none

module miss_control import dcache_pkg::*; (
	input wire clk,
	input wire reset,
	input wire req_valid,
	input wire cache_req_t req,
	input wire inval_valid,
	input wire lookup_t lookup,
	input wire wb_done,
	input wire fill_done,
	output cache_status_e status,
	output logic install,
	output logic clean_victim,
	output logic touch_hit,
	output logic write_hit,
	output logic issue_wb,
	output logic issue_fill
);

	typedef enum logic [1:0] {
		s_idle,
		s_wait_wb,
		s_wait_fill
	} state_e;

	state_e state_q;
	state_e state_d;
	logic req_active;

	assign req_active = req_valid && req.op != op_none;

	always_comb begin
		state_d = state_q;
		status = st_idle;
		install = 1'b0;
		clean_victim = 1'b0;
		touch_hit = 1'b0;
		write_hit = 1'b0;
		issue_wb = 1'b0;
		issue_fill = 1'b0;
		case (state_q)
			s_idle: begin
				// snoop owns the cycle
				if (req_active && !inval_valid) begin
					if (lookup.hit) begin
						status = st_hit;
						touch_hit = 1'b1;
						write_hit = req.op == op_write;
					end else begin
						status = st_miss;
						if (lookup.victim_dirty) begin
							issue_wb = 1'b1;
							state_d = s_wait_wb;
						end else begin
							issue_fill = 1'b1;
							state_d = s_wait_fill;
						end
					end
				end
			end
			s_wait_wb: begin
				status = st_wait;
				if (wb_done) begin
					clean_victim = 1'b1; // next lookup sees a clean miss
					state_d = s_idle;
				end
			end
			s_wait_fill: begin
				status = st_wait;
				if (fill_done) begin
					install = 1'b1;
					state_d = s_idle;
				end
			end
			default: begin
				state_d = s_idle;
			end
		endcase
		if (!req_valid)
			status = st_idle;
		else if (inval_valid)
			status = st_miss;
	end

	always_ff @(posedge clk) begin
		if (reset)
			state_q <= s_idle;
		else
			state_q <= state_d;
	end

	// the victim must be clean once its writeback is done
	a_clean_after_wb: assert property (@(posedge clk) disable iff (reset)
		clean_victim |=> !lookup.victim_dirty)
		else $error("Error %0t lookup.victim_dirty expected 0 got 1 after writeback", $time);

endmodule

`default_nettype wire

// File: test/dcache_mem_model.sv
// behavioral line memory with random done delays and an address pattern for untouched lines
`timescale 1ns/1ns
`default_nettype none

module dcache_mem_model import dcache_pkg::*; (
	input wire clk,
	input wire reset,
	input wire wb_start,
	input wire wb_req_t wb,
	input wire fill_start,
	input wire [addr_w-1:0] fill_addr,
	output logic wb_done,
	output logic fill_done,
	output logic [line_w-1:0] fill_data
);

	localparam logic [word_w-1:0] pattern_key = 64'h5a3c_0f96_c3a5_1e78;

	logic [line_w-1:0] mem [logic [addr_w-1:0]];
	integer seed = 33;
	int wait_cnt = 0;
	logic fill_pending = 1'b0;
	logic [addr_w-1:0] pending_addr = '0;
	logic saw_wb;
	logic saw_fill;

	// each untouched word holds its own byte address mixed with the key
	function automatic logic [line_w-1:0] line_at(input logic [addr_w-1:0] a);
		logic [line_w-1:0] l;
		if (mem.exists(a))
			return mem[a];
		for (int w = 0; w < words_per_line; w++)
			l[word_w*w +: word_w] = (a + 64'(8*w)) ^ pattern_key;
		return l;
	endfunction

	initial begin
		wb_done = 1'b0;
		fill_done = 1'b0;
		fill_data = '0;
		forever begin
			@(posedge clk);
			saw_wb = wb_start && !reset;
			saw_fill = fill_start && !reset;
			if (saw_wb)
				mem[wb.addr] = wb.line; // stored as the start is seen
			if (saw_fill)
				pending_addr = fill_addr;
			#1;
			wb_done = 1'b0;
			fill_done = 1'b0;
			if (saw_wb || saw_fill) begin
				wait_cnt = 1 + ($unsigned($random(seed)) % 6);
				fill_pending = saw_fill;
			end
			if (wait_cnt > 0) begin
				wait_cnt--;
				if (wait_cnt == 0 && fill_pending) begin
					fill_data = line_at(pending_addr);
					fill_done = 1'b1;
				end else if (wait_cnt == 0) begin
					wb_done = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: test/dcache_tb.sv
// cache testbench with clock, reset, access sequences, byte shadow of memory and checks
`timescale 1ns/1ns
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

	localparam logic [word_w-1:0] pattern_key = 64'h5a3c_0f96_c3a5_1e78;
	localparam int reset_cycles = 16;
	localparam int num_accesses = 12;
	localparam int cycle_limit = num_accesses * 20 + reset_cycles;
	// three lines sharing set 5
	localparam logic [addr_w-1:0] addr_a = {49'd1, 9'd5, 6'd8};
	localparam logic [addr_w-1:0] addr_b = {49'd2, 9'd5, 6'd16};
	localparam logic [addr_w-1:0] addr_c = {49'd3, 9'd5, 6'd48};

	logic clk;
	logic reset;
	logic req_valid;
	cache_req_t req;
	logic inval_valid;
	cache_addr_u inval_addr;
	logic wb_done;
	logic fill_done;
	logic [line_w-1:0] fill_data;
	cache_status_e status;
	logic [word_w-1:0] read_data;
	logic wb_start;
	wb_req_t wb;
	logic fill_start;
	logic [addr_w-1:0] fill_addr;

	logic expect_hit = 1'b0;
	logic fill_expected = 1'b0;
	logic wb_expected = 1'b0;
	logic [word_w-1:0] exp_word = '0;
	logic [addr_w-1:0] exp_wb_addr = '0;
	logic [line_w-1:0] exp_wb_line = '0;
	int fill_cnt = 0;
	int wb_cnt = 0;
	int fill_base = 0;
	int wb_base = 0;
	int cycles = 0;
	int errors = 0;
	int tests = 0;
	logic [7:0] shadow [logic [addr_w-1:0]];

	dcache_top dut_i (.*);
	dcache_mem_model mem_i (.*);

	function automatic logic [7:0] shadow_byte(input logic [addr_w-1:0] a);
		logic [word_w-1:0] pat;
		pat = {a[addr_w-1:3], 3'b000} ^ pattern_key;
		if (shadow.exists(a))
			return shadow[a];
		return pat[8*a[2:0] +: 8];
	endfunction

	function automatic logic [word_w-1:0] shadow_word(input logic [addr_w-1:0] a);
		logic [word_w-1:0] w;
		for (int b = 0; b < 8; b++)
			w[8*b +: 8] = shadow_byte({a[addr_w-1:3], 3'(b)});
		return w;
	endfunction

	function automatic logic [line_w-1:0] shadow_line(input logic [addr_w-1:0] a);
		logic [line_w-1:0] l;
		for (int i = 0; i < words_per_line; i++)
			l[word_w*i +: word_w] = shadow_word(a + 64'(8*i));
		return l;
	endfunction

	task automatic log_mismatch(input string name, input logic [line_w-1:0] expected,
			input logic [line_w-1:0] actual);
		errors++;
		$display("Error %0t %s expected %0h got %0h", $time, name, expected, actual);
	endtask

	task automatic log_failure(input string what);
		errors++;
		$display("Error %0t %s", $time, what);
	endtask

	task automatic report(input string name);
		tests++;
		$display("test %0d %s finished, %0d errors so far", tests, name, errors);
	endtask

	// holds the request until st_hit, then commits the write into the shadow
	task automatic access(input cache_op_e op, input logic [addr_w-1:0] a,
			input logic [word_w-1:0] data, input logic [7:0] be,
			input logic hit_now, input logic fill_now, input logic wb_now);
		exp_word = shadow_word(a);
		expect_hit = hit_now;
		fill_expected = fill_now;
		wb_expected = wb_now;
		fill_base = fill_cnt;
		wb_base = wb_cnt;
		req.op = op;
		req.addr.raw = a;
		req.wdata = data;
		req.byte_en = be;
		req_valid = 1'b1;
		do
			@(negedge clk);
		while (status != st_hit);
		@(posedge clk);
		#1;
		for (int b = 0; b < 8; b++)
			if (op == op_write && be[b])
				shadow[{a[addr_w-1:3], 3'(b)}] = data[8*b +: 8];
		req_valid = 1'b0;
		expect_hit = 1'b0;
		fill_expected = 1'b0;
		wb_expected = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (fill_start)
			fill_cnt <= fill_cnt + 1;
		if (wb_start)
			wb_cnt <= wb_cnt + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, an access never completed", cycles);
			$display("sim failed");
			$finish;
		end
	end

	a_idle: assert property (@(posedge clk) disable iff (reset)
		!req_valid |-> status == st_idle)
		else log_mismatch("status", line_w'(st_idle), line_w'($sampled(status)));
	a_hit: assert property (@(posedge clk) disable iff (reset)
		req_valid && expect_hit |-> status == st_hit)
		else log_mismatch("status", line_w'(st_hit), line_w'($sampled(status)));
	a_read: assert property (@(posedge clk) disable iff (reset)
		req_valid && req.op == op_read && status == st_hit |-> read_data == exp_word)
		else log_mismatch("read_data", line_w'($sampled(exp_word)),
			line_w'($sampled(read_data)));
	a_miss: assert property (@(posedge clk) disable iff (reset)
		req_valid && !inval_valid && status == st_miss |=>
		status == st_wait && (wb_start || fill_start))
		else log_failure("miss was not followed by st_wait and a transfer start");
	a_refill: assert property (@(posedge clk) disable iff (reset)
		status == st_wait && fill_done |=> status == st_hit)
		else log_failure("refill done was not followed by st_hit");
	a_fill_start: assert property (@(posedge clk) disable iff (reset)
		fill_start |-> fill_expected && (!wb_expected || wb_cnt != wb_base))
		else log_failure("fill_start without an expected miss or before the writeback");
	a_fill_addr: assert property (@(posedge clk) disable iff (reset)
		fill_start |-> fill_addr == {req.addr.raw[addr_w-1:offset_w], 6'b0})
		else log_mismatch("fill_addr",
			line_w'({$sampled(req.addr.raw[addr_w-1:offset_w]), 6'b0}),
			line_w'($sampled(fill_addr)));
	a_fill_seen: assert property (@(posedge clk) disable iff (reset)
		req_valid && status == st_hit && fill_expected |-> fill_cnt != fill_base)
		else log_failure("access completed without the expected refill");
	a_wb_start: assert property (@(posedge clk) disable iff (reset)
		wb_start |-> wb_expected)
		else log_failure("wb_start without a dirty victim");
	a_wb_addr: assert property (@(posedge clk) disable iff (reset)
		wb_start |-> wb.addr == exp_wb_addr)
		else log_mismatch("wb.addr", line_w'(exp_wb_addr), line_w'($sampled(wb.addr)));
	a_wb_line: assert property (@(posedge clk) disable iff (reset)
		wb_start |-> wb.line == exp_wb_line)
		else log_mismatch("wb.line", exp_wb_line, $sampled(wb.line));

	initial begin
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		inval_valid = 1'b0;
		inval_addr = '0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		report("idle after reset");
		access(op_read, addr_a, '0, '0, 1'b0, 1'b1, 1'b0);
		access(op_read, addr_a, '0, '0, 1'b1, 1'b0, 1'b0);
		report("cold read");
		access(op_write, addr_a, 64'h1122_3344_5566_7788, 8'b0101_1010, 1'b1, 1'b0, 1'b0);
		access(op_read, addr_a, '0, '0, 1'b1, 1'b0, 1'b0);
		report("byte-enabled write");
		access(op_read, addr_b, '0, '0, 1'b0, 1'b1, 1'b0);
		access(op_write, addr_b, 64'h0f1e_2d3c_4b5a_6978, 8'hff, 1'b1, 1'b0, 1'b0);
		access(op_read, addr_a, '0, '0, 1'b1, 1'b0, 1'b0); // b is now lru
		exp_wb_addr = {addr_b[addr_w-1:offset_w], 6'b0};
		exp_wb_line = shadow_line(exp_wb_addr);
		access(op_read, addr_c, '0, '0, 1'b0, 1'b1, 1'b1);
		access(op_read, addr_a, '0, '0, 1'b1, 1'b0, 1'b0);
		access(op_read, addr_b, '0, '0, 1'b0, 1'b1, 1'b0); // clean c goes quietly
		report("replacement");
		inval_valid = 1'b1;
		inval_addr.raw = addr_b;
		@(posedge clk);
		#1;
		inval_valid = 1'b0;
		access(op_read, addr_a, '0, '0, 1'b1, 1'b0, 1'b0);
		access(op_read, addr_b, '0, '0, 1'b0, 1'b1, 1'b0);
		report("invalidation");
		repeat (4) @(posedge clk);
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
